// ==== Bender.yml ====
package:
  name: score_overlay

sources:
  # Package first, then leaf modules up to the top level
  - design/score_gfx_pkg.sv
  - design/segment_decoder.sv
  - design/digit_renderer.sv
  - design/pixel_compositor.sv
  - design/score_overlay.sv

  - target: test
    include_dirs:
      - bench
    files:
      - bench/score_overlay_tb.sv

// ==== bench/score_model.svh ====
`ifndef SCORE_MODEL_SVH
`define SCORE_MODEL_SVH

// Lit segments per value built one segment at a time
function automatic score_gfx_pkg::seg_mask_t model_mask(input int value);
	score_gfx_pkg::seg_mask_t mask;
	mask = '0;
	if (value >= 0 && value <= 9)
	begin
		mask[0] = !(value == 1 || value == 4);
		mask[1] = !(value == 5 || value == 6);
		mask[2] = (value != 2);
		mask[3] = !(value == 1 || value == 4 || value == 7);
		mask[4] = (value == 0 || value == 2 || value == 6 || value == 8);
		mask[5] = !(value == 1 || value == 2 || value == 3 || value == 7);
		mask[6] = !(value == 0 || value == 1 || value == 7);
	end
	return mask;
endfunction

function automatic int seg_cx(input int s, input int dx);
	case (s)
		1, 2:
			return dx + score_gfx_pkg::DIGIT_WIDTH_HALF;
		4, 5:
			return dx - score_gfx_pkg::DIGIT_WIDTH_HALF;
		default:
			return dx;
	endcase
endfunction

function automatic int seg_cy(input int s, input int dy);
	case (s)
		0:
			return dy - 2 * score_gfx_pkg::DIGIT_WIDTH_HALF;
		1, 5:
			return dy - score_gfx_pkg::DIGIT_WIDTH_HALF;
		2, 4:
			return dy + score_gfx_pkg::DIGIT_WIDTH_HALF;
		3:
			return dy + 2 * score_gfx_pkg::DIGIT_WIDTH_HALF;
		default:
			return dy;
	endcase
endfunction

// Top, bottom and middle are the flat ones
function automatic int seg_half_x(input int s);
	if (s == 0 || s == 3 || s == 6)
		return score_gfx_pkg::DIGIT_WIDTH_HALF;
	return score_gfx_pkg::DIGIT_THICKNESS_HALF;
endfunction

function automatic int seg_half_y(input int s);
	if (s == 0 || s == 3 || s == 6)
		return score_gfx_pkg::DIGIT_THICKNESS_HALF;
	return score_gfx_pkg::DIGIT_WIDTH_HALF;
endfunction

// Plain int math is wide enough that nothing wraps
function automatic logic digit_lit(input int px, input int py, input int dx, input int dy,
	input int value);
	score_gfx_pkg::seg_mask_t mask;
	int cx;
	int cy;
	logic lit;
	mask = model_mask(value);
	lit = 1'b0;
	for (int s = 0; s < score_gfx_pkg::NUM_SEGS; s++)
	begin
		cx = seg_cx(s, dx);
		cy = seg_cy(s, dy);
		if (mask[s] && px >= cx - seg_half_x(s) && px <= cx + seg_half_x(s) &&
			py >= cy - seg_half_y(s) && py <= cy + seg_half_y(s))
			lit = 1'b1;
	end
	return lit;
endfunction

function automatic logic divider_lit(input int px, input int py);
	return px >= score_gfx_pkg::DIVIDER_X - score_gfx_pkg::DIVIDER_HALF &&
		px <= score_gfx_pkg::DIVIDER_X + score_gfx_pkg::DIVIDER_HALF &&
		py >= 0 && py <= score_gfx_pkg::DIVIDER_Y_MAX;
endfunction

// Packed as red, green, blue from the top bit down
function automatic logic [7:0] expected_colour(input logic divider, input logic digit);
	if (divider)
		return {score_gfx_pkg::DIVIDER_RED, score_gfx_pkg::DIVIDER_GREEN,
			score_gfx_pkg::DIVIDER_BLUE};
	if (digit)
		return {score_gfx_pkg::DIGIT_RED, score_gfx_pkg::DIGIT_GREEN,
			score_gfx_pkg::DIGIT_BLUE};
	return 8'h00;
endfunction

`endif

// ==== bench/score_overlay_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module score_overlay_tb;

	localparam int CLK_HALF     = 20;
	localparam int RESET_CYCLES = 16;
	localparam int WAIT_LIMIT   = 16;

	logic clk;
	logic arst_n;
	score_gfx_pkg::pixel_t pixel_x;
	score_gfx_pkg::pixel_t pixel_y;
	// Digit order is p1 tens, p1 units, p2 tens, p2 units
	score_gfx_pkg::pos_t   dig_x [4];
	score_gfx_pkg::pos_t   dig_y [4];
	score_gfx_pkg::score_t dig_v [4];
	score_gfx_pkg::red_t   red;
	score_gfx_pkg::green_t green;
	score_gfx_pkg::blue_t  blue;

	logic [7:0] exp_hist [2];
	int edges = 0;
	integer seed;

	`include "score_model.svh"

	score_overlay u_score_overlay (
		.clk        (clk),
		.arst_n     (arst_n),
		.pixel_x    (pixel_x),
		.pixel_y    (pixel_y),
		.p1_tens_x  (dig_x[0]),
		.p1_tens_y  (dig_y[0]),
		.p1_units_x (dig_x[1]),
		.p1_units_y (dig_y[1]),
		.p2_tens_x  (dig_x[2]),
		.p2_tens_y  (dig_y[2]),
		.p2_units_x (dig_x[3]),
		.p2_units_y (dig_y[3]),
		.p1_tens    (dig_v[0]),
		.p1_units   (dig_v[1]),
		.p2_tens    (dig_v[2]),
		.p2_units   (dig_v[3]),
		.red        (red),
		.green      (green),
		.blue       (blue)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#CLK_HALF clk = ~clk;
	end

	////////////////////
	// Checking
	////////////////////

	task automatic stop_with_failure();
		$display("CHECKS FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		$display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
		stop_with_failure();
	endtask

	// Inputs seen at this edge give the colour two edges later
	always @(posedge clk)
	begin
		logic any_digit;
		logic [7:0] exp_now;
		any_digit = 1'b0;
		for (int d = 0; d < score_gfx_pkg::NUM_DIGITS; d++)
			any_digit = any_digit | digit_lit(pixel_x, pixel_y, dig_x[d], dig_y[d], dig_v[d]);
		exp_now = arst_n ? expected_colour(divider_lit(pixel_x, pixel_y), any_digit) : 8'h00;
		if (edges > 0)
		begin
			assert (red === exp_hist[1][7:5])
			else
				report_mismatch("red", exp_hist[1][7:5], red);
			assert (green === exp_hist[1][4:2])
			else
				report_mismatch("green", exp_hist[1][4:2], green);
			assert (blue === exp_hist[1][1:0])
			else
				report_mismatch("blue", exp_hist[1][1:0], blue);
		end
		exp_hist[1] <= exp_hist[0];
		exp_hist[0] <= exp_now;
		edges <= edges + 1;
	end

	////////////////////
	// Stimulus
	////////////////////

	task automatic drive_pixel(input int x, input int y);
		@(posedge clk);
		pixel_x <= score_gfx_pkg::pixel_t'(x);
		pixel_y <= score_gfx_pkg::pixel_t'(y);
	endtask

	task automatic set_digit(input int d, input int x, input int y, input int v);
		@(posedge clk);
		dig_x[d] <= score_gfx_pkg::pos_t'(x);
		dig_y[d] <= score_gfx_pkg::pos_t'(y);
		dig_v[d] <= score_gfx_pkg::score_t'(v);
	endtask

	task automatic wait_for_colour(input logic [7:0] want, input string what);
		int n;
		n = 0;
		while ({red, green, blue} !== want)
		begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT)
			begin
				$display("Timeout: the output never showed %s", what);
				stop_with_failure();
			end
		end
	endtask

	task automatic check_divider();
		drive_pixel(400, 300);
		wait_for_colour(8'hff, "a white divider pixel");
		for (int y = 0; y <= score_gfx_pkg::DIVIDER_Y_MAX + 1; y++)
			for (int x = 398; x <= 402; x++)
				drive_pixel(x, y);
	endtask

	// Centres and one pixel past each box edge when asked
	task automatic sweep_digits(input int first, input int last, input logic edges_too);
		int cx;
		int cy;
		int hx;
		int hy;
		for (int d = 0; d < score_gfx_pkg::NUM_DIGITS; d++)
			for (int v = first; v <= last; v++)
			begin
				set_digit(d, dig_x[d], dig_y[d], v);
				for (int s = 0; s < score_gfx_pkg::NUM_SEGS; s++)
				begin
					cx = seg_cx(s, dig_x[d]);
					cy = seg_cy(s, dig_y[d]);
					hx = seg_half_x(s);
					hy = seg_half_y(s);
					drive_pixel(cx, cy);
					if (edges_too)
					begin
						drive_pixel(cx - hx - 1, cy);
						drive_pixel(cx + hx + 1, cy);
						drive_pixel(cx, cy - hy - 1);
						drive_pixel(cx, cy + hy + 1);
					end
				end
			end
	endtask

	// Digit hanging off the top left corner with the far side left dark
	task automatic check_screen_edge();
		set_digit(0, 5, 15, 8);
		for (int y = 0; y <= 48; y++)
		begin
			for (int x = 0; x <= 24; x++)
				drive_pixel(x, y < 41 ? y : 2040 + y - 41);
			for (int x = 2035; x <= 2047; x++)
				drive_pixel(x, y < 41 ? y : 2040 + y - 41);
		end
		set_digit(0, 100, 100, 8);
	endtask

	task automatic stream_random(input int count);
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			if ($random(seed) & 1)
			begin
				pixel_x <= score_gfx_pkg::pixel_t'(80 + {$random(seed)} % 620);
				pixel_y <= score_gfx_pkg::pixel_t'(70 + {$random(seed)} % 60);
			end
			else
			begin
				pixel_x <= score_gfx_pkg::pixel_t'($random(seed));
				pixel_y <= score_gfx_pkg::pixel_t'($random(seed));
			end
			for (int d = 0; d < score_gfx_pkg::NUM_DIGITS; d++)
				dig_v[d] <= score_gfx_pkg::score_t'($random(seed));
		end
	endtask

	initial
	begin
		seed = 32'ha00f02d9;
		arst_n = 1'b0;
		// A divider pixel through reset must still come out black
		pixel_x = score_gfx_pkg::pixel_t'(score_gfx_pkg::DIVIDER_X);
		pixel_y = '0;
		exp_hist[0] = 8'h00;
		exp_hist[1] = 8'h00;
		// Two digits each side, well clear of the divider
		for (int d = 0; d < score_gfx_pkg::NUM_DIGITS; d++)
		begin
			dig_x[d] = score_gfx_pkg::pos_t'((d < 2 ? 100 : 540) + 60 * d);
			dig_y[d] = score_gfx_pkg::pos_t'(100);
			dig_v[d] = score_gfx_pkg::score_t'(8);
		end
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;

		check_divider();
		sweep_digits(0, 9, 1'b1);
		sweep_digits(10, 15, 1'b0);
		check_screen_edge();
		stream_random(3000);

		// Flush the last pixels through the pipeline
		repeat (3) drive_pixel(0, 700);
		wait_for_colour(8'h00, "black after the last pixel");
		drive_pixel(0, 700);

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/digit_renderer.sv ====
`timescale 1ns/1ns
`default_nettype none

module digit_renderer (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire score_gfx_pkg::pixel_t   pixel_x,
	input  wire score_gfx_pkg::pixel_t   pixel_y,
	input  wire score_gfx_pkg::pos_t     digit_x,
	input  wire score_gfx_pkg::pos_t     digit_y,
	input  wire score_gfx_pkg::score_t   score,
	output logic                         digit_hit
);

	score_gfx_pkg::seg_mask_t seg_mask;
	score_gfx_pkg::seg_mask_t seg_in_box;

	score_gfx_pkg::coord_t px;
	score_gfx_pkg::coord_t py;
	score_gfx_pkg::coord_t dx;
	score_gfx_pkg::coord_t dy;
	score_gfx_pkg::coord_t w_half;
	score_gfx_pkg::coord_t t_half;

	score_gfx_pkg::coord_t seg_cx [score_gfx_pkg::NUM_SEGS];
	score_gfx_pkg::coord_t seg_cy [score_gfx_pkg::NUM_SEGS];

	logic hit_next;

	segment_decoder u_segment_decoder (
		.score    (score),
		.seg_mask (seg_mask)
	);

	// Zero extend into the signed compare width
	assign px = score_gfx_pkg::coord_t'(pixel_x);
	assign py = score_gfx_pkg::coord_t'(pixel_y);
	assign dx = score_gfx_pkg::coord_t'(digit_x);
	assign dy = score_gfx_pkg::coord_t'(digit_y);

	assign w_half = score_gfx_pkg::coord_t'(score_gfx_pkg::DIGIT_WIDTH_HALF);
	assign t_half = score_gfx_pkg::coord_t'(score_gfx_pkg::DIGIT_THICKNESS_HALF);

	////////////////////
	// Segment centres
	////////////////////

	always_comb
	begin
		// Top
		seg_cx[0] = dx;
		seg_cy[0] = dy - w_half - w_half;
		// Upper right
		seg_cx[1] = dx + w_half;
		seg_cy[1] = dy - w_half;
		// Lower right
		seg_cx[2] = dx + w_half;
		seg_cy[2] = dy + w_half;
		// Bottom
		seg_cx[3] = dx;
		seg_cy[3] = dy + w_half + w_half;
		// Lower left
		seg_cx[4] = dx - w_half;
		seg_cy[4] = dy + w_half;
		// Upper left
		seg_cx[5] = dx - w_half;
		seg_cy[5] = dy - w_half;
		// Middle
		seg_cx[6] = dx;
		seg_cy[6] = dy;
	end

	////////////////////
	// Box tests
	////////////////////

	for (genvar i = 0; i < score_gfx_pkg::NUM_SEGS; i++)
	begin : g_seg
		score_gfx_pkg::coord_t half_x;
		score_gfx_pkg::coord_t half_y;

		// Vertical segments swap length and thickness
		assign half_x = score_gfx_pkg::SEG_HORIZ[i] ? w_half : t_half;
		assign half_y = score_gfx_pkg::SEG_HORIZ[i] ? t_half : w_half;

		assign seg_in_box[i] = (px >= seg_cx[i] - half_x) &&
			(px <= seg_cx[i] + half_x) &&
			(py >= seg_cy[i] - half_y) &&
			(py <= seg_cy[i] + half_y);
	end

	assign hit_next = |(seg_in_box & seg_mask);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			digit_hit <= 1'b0;
		else
			digit_hit <= hit_next;
	end

endmodule

`default_nettype wire

// ==== design/pixel_compositor.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_compositor (
	input  wire                                   clk,
	input  wire                                   arst_n,
	input  wire score_gfx_pkg::pixel_t            pixel_x,
	input  wire score_gfx_pkg::pixel_t            pixel_y,
	input  wire [score_gfx_pkg::NUM_DIGITS-1:0]   digit_hit,
	output score_gfx_pkg::red_t                   red,
	output score_gfx_pkg::green_t                 green,
	output score_gfx_pkg::blue_t                  blue
);

	logic divider_next;
	logic divider_q;

	// Rows start at zero so only the bottom edge needs a test
	assign divider_next =
		(pixel_x >= score_gfx_pkg::pixel_t'(score_gfx_pkg::DIVIDER_X -
			score_gfx_pkg::DIVIDER_HALF)) &&
		(pixel_x <= score_gfx_pkg::pixel_t'(score_gfx_pkg::DIVIDER_X +
			score_gfx_pkg::DIVIDER_HALF)) &&
		(pixel_y <= score_gfx_pkg::pixel_t'(score_gfx_pkg::DIVIDER_Y_MAX));

	////////////////////
	// Stage 1
	////////////////////

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			divider_q <= 1'b0;
		else
			divider_q <= divider_next;
	end

	////////////////////
	// Stage 2
	////////////////////

	// Digit hits arrive registered, in step with divider_q.
	// All digits share one colour, so their order collapses to an OR
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end
		else if (divider_q)
		begin
			red   <= score_gfx_pkg::DIVIDER_RED;
			green <= score_gfx_pkg::DIVIDER_GREEN;
			blue  <= score_gfx_pkg::DIVIDER_BLUE;
		end
		else if (|digit_hit)
		begin
			red   <= score_gfx_pkg::DIGIT_RED;
			green <= score_gfx_pkg::DIGIT_GREEN;
			blue  <= score_gfx_pkg::DIGIT_BLUE;
		end
		else
		begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== design/score_gfx_pkg.sv ====
`default_nettype none

package score_gfx_pkg;

	////////////////////
	// Widths
	////////////////////

	localparam int PIXEL_W    = 11;
	localparam int POS_W      = 12;
	localparam int SCORE_W    = 4;
	localparam int NUM_SEGS   = 7;
	localparam int NUM_DIGITS = 4;

	localparam int RED_W   = 3;
	localparam int GREEN_W = 3;
	localparam int BLUE_W  = 2;

	typedef logic [PIXEL_W-1:0]  pixel_t;
	typedef logic [POS_W-1:0]    pos_t;
	typedef logic [SCORE_W-1:0]  score_t;
	typedef logic [NUM_SEGS-1:0] seg_mask_t;

	typedef logic [RED_W-1:0]   red_t;
	typedef logic [GREEN_W-1:0] green_t;
	typedef logic [BLUE_W-1:0]  blue_t;

	// One bit over the position width so boxes near an edge never wrap
	typedef logic signed [POS_W:0] coord_t;

	////////////////////
	// Geometry
	////////////////////

	localparam int DIGIT_WIDTH_HALF     = 10;
	localparam int DIGIT_THICKNESS_HALF = 2;

	localparam int DIVIDER_X     = 400;
	localparam int DIVIDER_HALF  = 1;
	localparam int DIVIDER_Y_MAX = 600;

	// Segments 0, 3 and 6 lie flat
	localparam seg_mask_t SEG_HORIZ = 7'b100_1001;

	////////////////////
	// Colours
	////////////////////

	localparam red_t   DIGIT_RED   = '1;
	localparam green_t DIGIT_GREEN = '1;
	localparam blue_t  DIGIT_BLUE  = '1;

	localparam red_t   DIVIDER_RED   = '1;
	localparam green_t DIVIDER_GREEN = '1;
	localparam blue_t  DIVIDER_BLUE  = '1;

endpackage

`default_nettype wire

// ==== design/score_overlay.sv ====
`timescale 1ns/1ns
`default_nettype none

module score_overlay (
	input  wire                          clk,
	input  wire                          arst_n,
	input  wire score_gfx_pkg::pixel_t   pixel_x,
	input  wire score_gfx_pkg::pixel_t   pixel_y,
	input  wire score_gfx_pkg::pos_t     p1_tens_x,
	input  wire score_gfx_pkg::pos_t     p1_tens_y,
	input  wire score_gfx_pkg::pos_t     p1_units_x,
	input  wire score_gfx_pkg::pos_t     p1_units_y,
	input  wire score_gfx_pkg::pos_t     p2_tens_x,
	input  wire score_gfx_pkg::pos_t     p2_tens_y,
	input  wire score_gfx_pkg::pos_t     p2_units_x,
	input  wire score_gfx_pkg::pos_t     p2_units_y,
	input  wire score_gfx_pkg::score_t   p1_tens,
	input  wire score_gfx_pkg::score_t   p1_units,
	input  wire score_gfx_pkg::score_t   p2_tens,
	input  wire score_gfx_pkg::score_t   p2_units,
	output score_gfx_pkg::red_t          red,
	output score_gfx_pkg::green_t        green,
	output score_gfx_pkg::blue_t         blue
);

	// Bit 0 is player 1 tens, bit 3 player 2 units
	logic [score_gfx_pkg::NUM_DIGITS-1:0] digit_hit;

	////////////////////
	// Player 1
	////////////////////

	digit_renderer u_p1_tens (
		.clk       (clk),
		.arst_n    (arst_n),
		.pixel_x   (pixel_x),
		.pixel_y   (pixel_y),
		.digit_x   (p1_tens_x),
		.digit_y   (p1_tens_y),
		.score     (p1_tens),
		.digit_hit (digit_hit[0])
	);

	digit_renderer u_p1_units (
		.clk       (clk),
		.arst_n    (arst_n),
		.pixel_x   (pixel_x),
		.pixel_y   (pixel_y),
		.digit_x   (p1_units_x),
		.digit_y   (p1_units_y),
		.score     (p1_units),
		.digit_hit (digit_hit[1])
	);

	////////////////////
	// Player 2
	////////////////////

	digit_renderer u_p2_tens (
		.clk       (clk),
		.arst_n    (arst_n),
		.pixel_x   (pixel_x),
		.pixel_y   (pixel_y),
		.digit_x   (p2_tens_x),
		.digit_y   (p2_tens_y),
		.score     (p2_tens),
		.digit_hit (digit_hit[2])
	);

	digit_renderer u_p2_units (
		.clk       (clk),
		.arst_n    (arst_n),
		.pixel_x   (pixel_x),
		.pixel_y   (pixel_y),
		.digit_x   (p2_units_x),
		.digit_y   (p2_units_y),
		.score     (p2_units),
		.digit_hit (digit_hit[3])
	);

	// Divider test and colour output
	pixel_compositor u_pixel_compositor (
		.clk       (clk),
		.arst_n    (arst_n),
		.pixel_x   (pixel_x),
		.pixel_y   (pixel_y),
		.digit_hit (digit_hit),
		.red       (red),
		.green     (green),
		.blue      (blue)
	);

endmodule

`default_nettype wire

// ==== design/segment_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module segment_decoder (
	input  wire score_gfx_pkg::score_t     score,
	output score_gfx_pkg::seg_mask_t       seg_mask
);

	// Bit order 6..0 is middle, upper left, lower left, bottom,
	// lower right, upper right, top
	always_comb
	begin
		case (score)
			4'd0:
				seg_mask = 7'b011_1111;
			4'd1:
				seg_mask = 7'b000_0110;
			4'd2:
				seg_mask = 7'b101_1011;
			4'd3:
				seg_mask = 7'b100_1111;
			4'd4:
				seg_mask = 7'b110_0110;
			4'd5:
				seg_mask = 7'b110_1101;
			4'd6:
				seg_mask = 7'b111_1101;
			4'd7:
				seg_mask = 7'b000_0111;
			4'd8:
				seg_mask = 7'b111_1111;
			4'd9:
				seg_mask = 7'b110_1111;
			// Blank digit
			default:
				seg_mask = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+bench
design/score_gfx_pkg.sv
design/segment_decoder.sv
design/digit_renderer.sv
design/pixel_compositor.sv
design/score_overlay.sv
bench/score_overlay_tb.sv
